// File: rename_dispatch.f
rename_pkg.sv
inst_queue.sv
free_list.sv
rename_table.sv
preg_status.sv
rob_tracker.sv
dispatcher.sv
rename_dispatch.sv
rename_dispatch_properties.sv
tb_rename_dispatch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_dispatch -f rename_dispatch.f -o sim_rename_dispatch \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

# A simulator abort from a failed assertion counts as a failing run
./obj_dir/sim_rename_dispatch > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log

grep -q "test failed" sim.log && exit 1 || exit 0

// File: tb_rename_dispatch.sv
// Random traffic against a shadow model; writebacks and retires only target dispatched slots
`timescale 1ns/100ps

module tb_rename_dispatch;
    import rename_pkg::*;

    localparam int RUN_CYCLES = 2500;
    // Run, drain and reset with headroom
    localparam int CYCLE_LIMIT = RUN_CYCLES + 500;

    typedef dispatch_entry_t [ISSUE_WIDTH-1:0] entry_pair_t;

    // Dispatched slot waiting for writeback and retirement
    typedef struct packed {
        rob_id_t rob_id;
        preg_t preg_rd;
        preg_t preg_old;
        logic done;
    } flight_t;

    // Outcome of one clock edge
    typedef struct packed {
        logic fire;
        logic full;
        entry_pair_t entries;
    } expect_t;

    logic clk;
    logic rst;
    logic push;
    inst_bundle_t push_bundle;
    logic iq_full;
    logic rs_full;
    wb_t wb [ISSUE_WIDTH];
    retire_t retire [ISSUE_WIDTH];
    logic dispatch_valid;
    dispatch_entry_t entries [ISSUE_WIDTH];

    // Shadow state of the rename stage
    preg_t rat [ARCH_REGS];
    preg_t free_q [$];
    logic busy [PHYS_REGS];
    rob_id_t prod [PHYS_REGS];
    int rob_count;
    rob_id_t rob_tail;
    inst_bundle_t iq_q [$];
    flight_t flight_q [$];
    expect_t exp_q [$];

    int cycle_cnt;
    int err_count;
    int check_count;
    int fire_count;
    logic [31:0] pc_seq;
    logic draining;

    rename_dispatch rename_dispatch_i (
        .clk(clk), .rst(rst), .push(push), .push_bundle(push_bundle), .iq_full(iq_full),
        .rs_full(rs_full), .wb(wb), .retire(retire), .dispatch_valid(dispatch_valid),
        .entries(entries)
    );

    always #2 clk = ~clk;

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            rat[i] = preg_t'(i);
        end
        free_q.delete();
        // Upper half starts free
        for (int i = 0; i < FREE_DEPTH; i++) begin
            free_q.push_back(preg_t'(ARCH_REGS + i));
        end
        for (int p = 0; p < PHYS_REGS; p++) begin
            busy[p] = 1'b0;
            prod[p] = '0;
        end
        rob_count = 0;
        rob_tail = '0;
        iq_q.delete();
        flight_q.delete();
        exp_q.delete();
    endtask

    function automatic dec_inst_t random_inst(logic [31:0] pc);
        dec_inst_t d;
        d.valid = 1'b1;
        d.pc = pc;
        d.inst = $urandom;
        // Few registers so dependencies and x0 show up often
        d.rs1 = arch_reg_t'($urandom_range(7));
        d.rs2 = arch_reg_t'($urandom_range(7));
        d.rd = arch_reg_t'($urandom_range(7));
        d.use_rs1 = ($urandom_range(3) != 0);
        d.use_rs2 = ($urandom_range(1) != 0);
        d.writes_rd = ($urandom_range(3) != 0);
        return d;
    endfunction

    // Ready unless a register operand waits on a busy preg
    function automatic logic source_ready(logic use_reg, preg_t p);
        logic cleared;
        cleared = 1'b0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            if (wb[w].valid && wb[w].preg == p) begin
                cleared = 1'b1;
            end
        end
        return !use_reg || (p == '0) || !busy[p] || cleared;
    endfunction

    function automatic entry_pair_t expect_bundle(inst_bundle_t b);
        entry_pair_t e;
        logic w [ISSUE_WIDTH];
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            w[i] = b[i].writes_rd && (b[i].rd != '0);
            e[i].inst = b[i];
            e[i].rob_id = rob_tail + rob_id_t'(i);
            e[i].preg_rs1 = rat[b[i].rs1];
            e[i].preg_rs2 = rat[b[i].rs2];
            e[i].preg_rd = w[i] ? free_q[i] : '0;
            // A slot that renames nothing hands its preg straight back
            e[i].preg_old = w[i] ? rat[b[i].rd] : free_q[i];
        end
        // Slot 1 names see slot 0's new register
        if (w[0]) begin
            if (b[1].rs1 == b[0].rd) begin
                e[1].preg_rs1 = free_q[0];
            end
            if (b[1].rs2 == b[0].rd) begin
                e[1].preg_rs2 = free_q[0];
            end
            if (w[1] && b[1].rd == b[0].rd) begin
                e[1].preg_old = free_q[0];
            end
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            e[i].src1_ready = source_ready(b[i].use_rs1, e[i].preg_rs1);
            e[i].src2_ready = source_ready(b[i].use_rs2, e[i].preg_rs2);
            e[i].src1_rob = e[i].src1_ready ? '0 : prod[e[i].preg_rs1];
            e[i].src2_rob = e[i].src2_ready ? '0 : prod[e[i].preg_rs2];
        end
        // Register operands on slot 0's result wait for slot 0
        if (w[0] && b[1].use_rs1 && b[1].rs1 == b[0].rd) begin
            e[1].src1_ready = 1'b0;
            e[1].src1_rob = e[0].rob_id;
        end
        if (w[0] && b[1].use_rs2 && b[1].rs2 == b[0].rd) begin
            e[1].src2_ready = 1'b0;
            e[1].src2_rob = e[0].rob_id;
        end
        return e;
    endfunction

    task automatic apply_stimulus();
        flight_t rec;
        int idx;
        logic retire_on;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            wb[w] = '0;
            retire[w] = '0;
        end
        // Complete random in-flight writers
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            if (flight_q.size() > 0 && $urandom_range(3) != 0) begin
                idx = int'($urandom_range(flight_q.size() - 1));
                rec = flight_q[idx];
                if (!rec.done) begin
                    wb[w].valid = 1'b1;
                    wb[w].preg = rec.preg_rd;
                    wb[w].rob_id = rec.rob_id;
                    rec.done = 1'b1;
                    flight_q[idx] = rec;
                end
            end
        end
        // Retirement pauses every third window so the ROB fills up
        retire_on = ((cycle_cnt / 64) % 3) != 0;
        for (int r = 0; r < ISSUE_WIDTH; r++) begin
            if (retire_on && (r == 0 || retire[0].valid) && flight_q.size() > 0
                    && flight_q[0].done && $urandom_range(2) != 0) begin
                rec = flight_q.pop_front();
                retire[r].valid = 1'b1;
                retire[r].preg_free = rec.preg_old;
            end
        end
        rs_full = ($urandom_range(3) == 0);
        push = !draining && ($urandom_range(4) < 3);
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            push_bundle[i] = random_inst(pc_seq + 32'(4 * i));
        end
        if (push) begin
            pc_seq = pc_seq + 32'd8;
        end
    endtask

    // Mirror the coming clock edge in the model
    task automatic predict_and_advance();
        expect_t x;
        logic can_push;
        flight_t rec;
        x.fire = iq_q.size() > 0 && free_q.size() >= 2 && (ROB_DEPTH - rob_count) >= 2
            && !rs_full;
        x.entries = '0;
        if (x.fire) begin
            x.entries = expect_bundle(iq_q[0]);
        end
        can_push = push && (iq_q.size() < IQ_DEPTH);
        // Writebacks clear first, a new mark wins
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            if (wb[w].valid) begin
                busy[wb[w].preg] = 1'b0;
            end
        end
        if (x.fire) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (x.entries[i].preg_rd != '0) begin
                    busy[x.entries[i].preg_rd] = 1'b1;
                    prod[x.entries[i].preg_rd] = x.entries[i].rob_id;
                    rat[x.entries[i].inst.rd] = x.entries[i].preg_rd;
                end
                rec.rob_id = x.entries[i].rob_id;
                rec.preg_rd = x.entries[i].preg_rd;
                rec.preg_old = x.entries[i].preg_old;
                rec.done = (x.entries[i].preg_rd == '0);
                flight_q.push_back(rec);
                void'(free_q.pop_front());
            end
            rob_tail = rob_tail + rob_id_t'(ISSUE_WIDTH);
            rob_count = rob_count + ISSUE_WIDTH;
            void'(iq_q.pop_front());
            fire_count++;
        end
        for (int r = 0; r < ISSUE_WIDTH; r++) begin
            if (retire[r].valid) begin
                free_q.push_back(retire[r].preg_free);
                rob_count--;
            end
        end
        if (can_push) begin
            iq_q.push_back(push_bundle);
        end
        x.full = (iq_q.size() == IQ_DEPTH);
        exp_q.push_back(x);
    endtask

    task automatic check_valid(logic got, logic exp, string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_entry(dispatch_entry_t got, dispatch_entry_t exp, int slot);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0d ns: slot %0d pc %h got %h expected %h",
                $time, slot, exp.inst.pc, got, exp);
        end
    endtask

    // Outputs settle 1 ns after the edge
    always @(posedge clk) begin
        expect_t x;
        #1;
        if (exp_q.size() > 0) begin
            x = exp_q.pop_front();
            check_valid(dispatch_valid, x.fire, "dispatch_valid");
            check_valid(iq_full, x.full, "iq_full");
            if (x.fire) begin
                for (int i = 0; i < ISSUE_WIDTH; i++) begin
                    check_entry(entries[i], x.entries[i], i);
                end
            end
        end else begin
            check_valid(dispatch_valid, 1'b0, "dispatch_valid");
            check_valid(iq_full, 1'b0, "iq_full");
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(27));
        clk = 1'b0;
        rst = 1'b1;
        push = 1'b0;
        push_bundle = '0;
        rs_full = 1'b0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            wb[w] = '0;
            retire[w] = '0;
        end
        err_count = 0;
        check_count = 0;
        fire_count = 0;
        pc_seq = '0;
        draining = 1'b0;
        reset_model();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            apply_stimulus();
            predict_and_advance();
            @(negedge clk);
        end
        // Stop pushing and let the queue empty
        draining = 1'b1;
        while (iq_q.size() != 0) begin
            apply_stimulus();
            predict_and_advance();
            @(negedge clk);
        end
        push = 1'b0;
        rs_full = 1'b0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            wb[w] = '0;
            retire[w] = '0;
        end
        repeat (2) @(negedge clk);
        $display("bundles dispatched: %0d, checks: %0d, errors: %0d",
            fire_count, check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: rename_dispatch_properties.sv
// Handshake timing checks only; bound into every dispatcher instance
`timescale 1ns/100ps

module rename_dispatch_properties (
    input logic clk,
    input logic rst,
    input logic rs_full,
    input logic fire,
    input logic dispatch_valid
);

    // Quiet output through reset
    reset_quiet_a: assert property (@(posedge clk) rst |=> !dispatch_valid)
        else $error("dispatch_valid high after a reset cycle");

    // Queue is empty on the first cycle out of reset
    first_cycle_quiet_a: assert property (@(posedge clk) $fell(rst) |=> !dispatch_valid)
        else $error("dispatch_valid high on the first cycle after reset");

    // Reservation station back-pressure blocks dispatch
    no_fire_when_full_a: assert property (@(posedge clk) disable iff (rst) !(fire && rs_full))
        else $error("fire while rs_full is high");

    // Every fire shows up as a dispatch one cycle later
    fire_then_valid_a: assert property (@(posedge clk) disable iff (rst) fire |=> dispatch_valid)
        else $error("fire not followed by dispatch_valid");

endmodule

bind dispatcher rename_dispatch_properties dispatcher_props_i (
    .clk(clk),
    .rst(rst),
    .rs_full(rs_full),
    .fire(fire),
    .dispatch_valid(dispatch_valid)
);

// File: rename_dispatch.sv
// Retire and writeback inputs are trusted to refer to dispatched work; no recovery path exists
`timescale 1ns/100ps

module rename_dispatch (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  rename_pkg::inst_bundle_t push_bundle,
    output logic iq_full,
    input  logic rs_full,
    input  rename_pkg::wb_t wb [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::retire_t retire [rename_pkg::ISSUE_WIDTH],
    output logic dispatch_valid,
    output rename_pkg::dispatch_entry_t entries [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    // Queue to dispatcher
    inst_bundle_t iq_head;
    logic iq_empty;
    logic fire;

    // Allocation sources
    preg_t new_preg [ISSUE_WIDTH];
    rob_id_t rob_ids [ISSUE_WIDTH];
    logic fl_avail;
    logic rob_avail;

    // RAT traffic
    arch_reg_t rat_rs1 [ISSUE_WIDTH];
    arch_reg_t rat_rs2 [ISSUE_WIDTH];
    arch_reg_t rat_rd [ISSUE_WIDTH];
    logic rat_we;
    preg_t rat_write_map [ISSUE_WIDTH];
    logic rat_write_mask [ISSUE_WIDTH];
    preg_t map_rs1 [ISSUE_WIDTH];
    preg_t map_rs2 [ISSUE_WIDTH];
    preg_t map_old [ISSUE_WIDTH];

    // Status traffic
    preg_t query_rs1 [ISSUE_WIDTH];
    preg_t query_rs2 [ISSUE_WIDTH];
    logic busy1 [ISSUE_WIDTH];
    logic busy2 [ISSUE_WIDTH];
    rob_id_t prod1 [ISSUE_WIDTH];
    rob_id_t prod2 [ISSUE_WIDTH];
    logic mark_en;
    preg_t mark_preg [ISSUE_WIDTH];
    logic mark_mask [ISSUE_WIDTH];
    rob_id_t mark_rob [ISSUE_WIDTH];

    inst_queue inst_queue_i (
        .clk(clk), .rst(rst), .push(push), .push_bundle(push_bundle), .pop(fire),
        .head(iq_head), .empty(iq_empty), .full(iq_full)
    );

    free_list free_list_i (
        .clk(clk), .rst(rst), .pop(fire), .alloc(new_preg), .avail(fl_avail),
        .retire(retire)
    );

    rob_tracker rob_tracker_i (
        .clk(clk), .rst(rst), .alloc(fire), .rob_ids(rob_ids), .avail(rob_avail),
        .retire(retire)
    );

    rename_table rename_table_i (
        .clk(clk), .rst(rst), .rs1(rat_rs1), .rs2(rat_rs2), .rd(rat_rd),
        .write_en(rat_we), .write_map(rat_write_map), .write_mask(rat_write_mask),
        .map_rs1(map_rs1), .map_rs2(map_rs2), .map_old(map_old)
    );

    preg_status preg_status_i (
        .clk(clk), .rst(rst), .query_rs1(query_rs1), .query_rs2(query_rs2),
        .busy1(busy1), .busy2(busy2), .prod1(prod1), .prod2(prod2),
        .mark_en(mark_en), .mark_preg(mark_preg), .mark_mask(mark_mask),
        .mark_rob(mark_rob), .wb(wb)
    );

    dispatcher dispatcher_i (
        .clk(clk), .rst(rst), .iq_head(iq_head), .iq_empty(iq_empty),
        .fl_avail(fl_avail), .rob_avail(rob_avail), .rs_full(rs_full), .fire(fire),
        .rat_rs1(rat_rs1), .rat_rs2(rat_rs2), .rat_rd(rat_rd), .rat_we(rat_we),
        .rat_write_map(rat_write_map), .rat_write_mask(rat_write_mask),
        .map_rs1(map_rs1), .map_rs2(map_rs2), .map_old(map_old),
        .query_rs1(query_rs1), .query_rs2(query_rs2), .busy1(busy1), .busy2(busy2),
        .prod1(prod1), .prod2(prod2), .mark_en(mark_en), .mark_preg(mark_preg),
        .mark_mask(mark_mask), .mark_rob(mark_rob), .new_preg(new_preg),
        .rob_ids(rob_ids), .dispatch_valid(dispatch_valid), .entries(entries)
    );

endmodule

// File: dispatcher.sv
// Slot 1 bypass logic assumes exactly two slots; entries hold their last value while idle
`timescale 1ns/100ps

module dispatcher (
    input  logic clk,
    input  logic rst,
    input  rename_pkg::inst_bundle_t iq_head,
    input  logic iq_empty,
    input  logic fl_avail,
    input  logic rob_avail,
    input  logic rs_full,
    output logic fire,
    // RAT query and update
    output rename_pkg::arch_reg_t rat_rs1 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::arch_reg_t rat_rs2 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::arch_reg_t rat_rd [rename_pkg::ISSUE_WIDTH],
    output logic rat_we,
    output rename_pkg::preg_t rat_write_map [rename_pkg::ISSUE_WIDTH],
    output logic rat_write_mask [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::preg_t map_rs1 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::preg_t map_rs2 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::preg_t map_old [rename_pkg::ISSUE_WIDTH],
    // Physical register status
    output rename_pkg::preg_t query_rs1 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::preg_t query_rs2 [rename_pkg::ISSUE_WIDTH],
    input  logic busy1 [rename_pkg::ISSUE_WIDTH],
    input  logic busy2 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::rob_id_t prod1 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::rob_id_t prod2 [rename_pkg::ISSUE_WIDTH],
    output logic mark_en,
    output rename_pkg::preg_t mark_preg [rename_pkg::ISSUE_WIDTH],
    output logic mark_mask [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::rob_id_t mark_rob [rename_pkg::ISSUE_WIDTH],
    // Allocations offered this cycle
    input  rename_pkg::preg_t new_preg [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::rob_id_t rob_ids [rename_pkg::ISSUE_WIDTH],
    output logic dispatch_valid,
    output rename_pkg::dispatch_entry_t entries [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    logic writes [ISSUE_WIDTH];
    dispatch_entry_t next_entry [ISSUE_WIDTH];

    function automatic logic src_ready(logic use_reg, preg_t p, logic busy);
        return !use_reg || (p == '0) || !busy;
    endfunction

    // All four resources must be there in the same cycle
    assign fire = !iq_empty && fl_avail && rob_avail && !rs_full;
    assign rat_we = fire;
    assign mark_en = fire;

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            // x0 writes rename nothing
            writes[i] = iq_head[i].writes_rd && (iq_head[i].rd != '0);
            rat_rs1[i] = iq_head[i].rs1;
            rat_rs2[i] = iq_head[i].rs2;
            rat_rd[i] = iq_head[i].rd;
            rat_write_map[i] = new_preg[i];
            rat_write_mask[i] = writes[i];
            query_rs1[i] = map_rs1[i];
            query_rs2[i] = map_rs2[i];
            mark_preg[i] = new_preg[i];
            mark_mask[i] = writes[i];
            mark_rob[i] = rob_ids[i];
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            next_entry[i].inst = iq_head[i];
            next_entry[i].rob_id = rob_ids[i];
            next_entry[i].preg_rs1 = map_rs1[i];
            next_entry[i].preg_rs2 = map_rs2[i];
            // Unused new preg goes back through preg_old
            next_entry[i].preg_rd = writes[i] ? new_preg[i] : '0;
            next_entry[i].preg_old = writes[i] ? map_old[i] : new_preg[i];
            next_entry[i].src1_ready = src_ready(iq_head[i].use_rs1, map_rs1[i], busy1[i]);
            next_entry[i].src2_ready = src_ready(iq_head[i].use_rs2, map_rs2[i], busy2[i]);
            next_entry[i].src1_rob = prod1[i];
            next_entry[i].src2_rob = prod2[i];
        end
        // Slot 1 waits on slot 0 when it reads slot 0's rd
        if (writes[0] && iq_head[1].use_rs1 && iq_head[1].rs1 == iq_head[0].rd) begin
            next_entry[1].src1_ready = 1'b0;
            next_entry[1].src1_rob = rob_ids[0];
        end
        if (writes[0] && iq_head[1].use_rs2 && iq_head[1].rs2 == iq_head[0].rd) begin
            next_entry[1].src2_ready = 1'b0;
            next_entry[1].src2_rob = rob_ids[0];
        end
        // Producer id only means something while waiting
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (next_entry[i].src1_ready) begin
                next_entry[i].src1_rob = '0;
            end
            if (next_entry[i].src2_ready) begin
                next_entry[i].src2_rob = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            entries <= next_entry;
        end
    end

endmodule

// File: rob_tracker.sv
// Alloc is taken only while avail is high; retires are assumed to match allocated slots
`timescale 1ns/100ps

module rob_tracker (
    input  logic clk,
    input  logic rst,
    input  logic alloc,
    output rename_pkg::rob_id_t rob_ids [rename_pkg::ISSUE_WIDTH],
    output logic avail,
    input  rename_pkg::retire_t retire [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    rob_id_t tail;
    logic [ROB_ID_W:0] count;
    logic [ROB_ID_W:0] free_slots;
    logic [ROB_ID_W:0] retire_cnt;
    logic [ROB_ID_W:0] alloc_cnt;

    // Two consecutive ids from the tail
    assign rob_ids[0] = tail;
    assign rob_ids[1] = tail + 1'b1;

    assign free_slots = $bits(free_slots)'(ROB_DEPTH) - count;
    assign avail = (free_slots >= 2);

    always_comb begin
        retire_cnt = retire[0].valid + retire[1].valid;
        alloc_cnt = '0;
        alloc_cnt[1] = alloc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 2'd2;
            end
            count <= count + alloc_cnt - retire_cnt;
        end
    end

endmodule

// File: preg_status.sv
// Producer ids hold stale values while a preg is not busy; preg 0 is never busy
`timescale 1ns/100ps

module preg_status (
    input  logic clk,
    input  logic rst,
    input  rename_pkg::preg_t query_rs1 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::preg_t query_rs2 [rename_pkg::ISSUE_WIDTH],
    output logic busy1 [rename_pkg::ISSUE_WIDTH],
    output logic busy2 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::rob_id_t prod1 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::rob_id_t prod2 [rename_pkg::ISSUE_WIDTH],
    input  logic mark_en,
    input  rename_pkg::preg_t mark_preg [rename_pkg::ISSUE_WIDTH],
    input  logic mark_mask [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::rob_id_t mark_rob [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::wb_t wb [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    logic busy [PHYS_REGS];
    rob_id_t prod [PHYS_REGS];

    // Writeback this cycle on the queried preg
    function automatic logic wb_hit(preg_t p);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            hit = hit || (wb[w].valid && wb[w].preg == p);
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            busy1[i] = busy[query_rs1[i]] && !wb_hit(query_rs1[i]);
            busy2[i] = busy[query_rs2[i]] && !wb_hit(query_rs2[i]);
            prod1[i] = prod[query_rs1[i]];
            prod2[i] = prod[query_rs2[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < PHYS_REGS; p++) begin
                busy[p] <= 1'b0;
            end
        end else begin
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (wb[w].valid) begin
                    busy[wb[w].preg] <= 1'b0;
                end
            end
            // Marks come last so they win over a writeback
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (mark_en && mark_mask[i] && mark_preg[i] != '0) begin
                    busy[mark_preg[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (mark_en && mark_mask[i]) begin
                prod[mark_preg[i]] <= mark_rob[i];
            end
        end
    end

endmodule

// File: rename_table.sv
// Bypass covers slot 1 only; x0 is never written and stays on preg 0
`timescale 1ns/100ps

module rename_table (
    input  logic clk,
    input  logic rst,
    input  rename_pkg::arch_reg_t rs1 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::arch_reg_t rs2 [rename_pkg::ISSUE_WIDTH],
    input  rename_pkg::arch_reg_t rd [rename_pkg::ISSUE_WIDTH],
    input  logic write_en,
    input  rename_pkg::preg_t write_map [rename_pkg::ISSUE_WIDTH],
    input  logic write_mask [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::preg_t map_rs1 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::preg_t map_rs2 [rename_pkg::ISSUE_WIDTH],
    output rename_pkg::preg_t map_old [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    preg_t map [ARCH_REGS];
    logic writes [ISSUE_WIDTH];

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            writes[i] = write_mask[i] && (rd[i] != '0);
        end
        // Slot 0 reads the table as it stands
        map_rs1[0] = map[rs1[0]];
        map_rs2[0] = map[rs2[0]];
        map_old[0] = map[rd[0]];
        // Slot 1 sees slot 0's new mapping
        map_rs1[1] = (writes[0] && rs1[1] == rd[0]) ? write_map[0] : map[rs1[1]];
        map_rs2[1] = (writes[0] && rs2[1] == rd[0]) ? write_map[0] : map[rs2[1]];
        map_old[1] = (writes[0] && rd[1] == rd[0]) ? write_map[0] : map[rd[1]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (write_en) begin
            // Later slot wins on the same rd
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (writes[i]) begin
                    map[rd[i]] <= write_map[i];
                end
            end
        end
    end

endmodule

// File: free_list.sv
// Pop is taken only while avail is high; retire pushes must never exceed 32 free entries
`timescale 1ns/100ps

module free_list (
    input  logic clk,
    input  logic rst,
    input  logic pop,
    output rename_pkg::preg_t alloc [rename_pkg::ISSUE_WIDTH],
    output logic avail,
    input  rename_pkg::retire_t retire [rename_pkg::ISSUE_WIDTH]
);
    import rename_pkg::*;

    preg_t mem [FREE_DEPTH];
    logic [$clog2(FREE_DEPTH)-1:0] head_ptr;
    logic [$clog2(FREE_DEPTH)-1:0] head_ptr1;
    logic [$clog2(FREE_DEPTH)-1:0] tail_ptr;
    // Write slot for retire slot 1, packed behind slot 0 when it is valid
    logic [$clog2(FREE_DEPTH)-1:0] tail_ptr1;
    logic [$clog2(FREE_DEPTH):0] count;
    logic [$clog2(FREE_DEPTH):0] push_cnt;
    logic [$clog2(FREE_DEPTH):0] pop_cnt;

    assign head_ptr1 = head_ptr + 1'b1;
    assign tail_ptr1 = tail_ptr + retire[0].valid;

    // Two head entries are offered every cycle
    assign alloc[0] = mem[head_ptr];
    assign alloc[1] = mem[head_ptr1];
    assign avail = (count >= 2);

    always_comb begin
        push_cnt = retire[0].valid + retire[1].valid;
        // Pop always takes two
        pop_cnt = '0;
        pop_cnt[1] = pop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Pregs above the architectural set start free, in order
            for (int i = 0; i < FREE_DEPTH; i++) begin
                mem[i] <= preg_t'(ARCH_REGS + i);
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= $bits(count)'(FREE_DEPTH);
        end else begin
            if (retire[0].valid) begin
                mem[tail_ptr] <= retire[0].preg_free;
            end
            if (retire[1].valid) begin
                mem[tail_ptr1] <= retire[1].preg_free;
            end
            tail_ptr <= tail_ptr1 + retire[1].valid;
            if (pop) begin
                head_ptr <= head_ptr + 2'd2;
            end
            // Rise and fall in the same cycle
            count <= count + push_cnt - pop_cnt;
        end
    end

endmodule

// File: inst_queue.sv
// Pushes while full are dropped and pops while empty are ignored; full and empty follow the count
`timescale 1ns/100ps

module inst_queue (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  rename_pkg::inst_bundle_t push_bundle,
    input  logic pop,
    output rename_pkg::inst_bundle_t head,
    output logic empty,
    output logic full
);
    import rename_pkg::*;

    inst_bundle_t mem [IQ_DEPTH];
    logic [$clog2(IQ_DEPTH)-1:0] rd_ptr;
    logic [$clog2(IQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(IQ_DEPTH):0] count;
    logic do_push;
    logic do_pop;

    // Qualified handshakes
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign head = mem[rd_ptr];
    assign empty = (count == 0);
    assign full = (count == IQ_DEPTH);

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Bundle storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_bundle;
        end
    end

endmodule

// File: rename_pkg.sv
// Two-wide fixed sizing with no per-module parameters, and at most 32 pregs are free at once
package rename_pkg;

    // Bundle width and register file sizes
    localparam int ISSUE_WIDTH = 2;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int PREG_W = 6;

    // ROB id space and queue depths
    localparam int ROB_DEPTH = 8;
    localparam int ROB_ID_W = 3;
    localparam int IQ_DEPTH = 4;
    localparam int FREE_DEPTH = 32;

    typedef logic [4:0] arch_reg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // One decoded instruction as it leaves decode
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] inst;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        // Operand comes from a register, not an immediate or pc
        logic use_rs1;
        logic use_rs2;
        logic writes_rd;
    } dec_inst_t;

    // Slot 0 sits in the low bits
    typedef dec_inst_t [ISSUE_WIDTH-1:0] inst_bundle_t;

    // One renamed slot headed for the reservation station and ROB
    typedef struct packed {
        dec_inst_t inst;
        rob_id_t rob_id;
        preg_t preg_rs1;
        preg_t preg_rs2;
        preg_t preg_rd;
        // Freed by retirement
        preg_t preg_old;
        logic src1_ready;
        logic src2_ready;
        // Producer ids, zero once the source is ready
        rob_id_t src1_rob;
        rob_id_t src2_rob;
    } dispatch_entry_t;

    // Result broadcast
    typedef struct packed {
        logic valid;
        preg_t preg;
        rob_id_t rob_id;
    } wb_t;

    // One retiring slot
    typedef struct packed {
        logic valid;
        preg_t preg_free;
    } retire_t;

endpackage
